//--- compile.f
rtl/rvIsaPkg.sv
rtl/cpuCfgPkg.sv
rtl/ctrlIf.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/dataMem.sv
rtl/execUnit.sv
rtl/instrMem.sv
rtl/singleCpu.sv
test/singleCpu_props.sv
test/singleCpuTb.sv

//--- rtl/cpuCfgPkg.sv
package cpuCfgPkg;

    // Both memories hold 64 words
    localparam int IMEM_DEPTH = 64;
    localparam int DMEM_DEPTH = 64;

    // Word index taken from byte address bits 7..2
    localparam int MEM_ADDR_LO = 2;
    localparam int MEM_ADDR_W  = 6;

    typedef logic [MEM_ADDR_W-1:0] memAddr_t;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage

//--- rtl/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf;
    import rvIsaPkg::*;

    logic     regWrite;
    logic     aluSrc;     // Immediate as second operand
    logic     memWrite;
    logic     memToReg;   // Load data to write-back
    logic     branch;
    aluCtrl_t aluCtrl;
    word_t    imm;

    modport dec (
        output regWrite, aluSrc, memWrite, memToReg, branch, aluCtrl, imm
    );

    modport exec (
        input regWrite, aluSrc, memWrite, memToReg, branch, aluCtrl, imm
    );

endinterface

//--- rtl/dataMem.sv
`timescale 1ns/1ps

module dataMem (
    input  logic            CLK,
    input  logic            rstN,
    input  logic            we,
    input  rvIsaPkg::word_t addr,
    input  rvIsaPkg::word_t wdata,
    output rvIsaPkg::word_t rdata
);
    import rvIsaPkg::*;
    import cpuCfgPkg::*;

    word_t    mem [DMEM_DEPTH];
    memAddr_t idx;

    assign idx   = addr[MEM_ADDR_LO +: MEM_ADDR_W];  // Word index
    assign rdata = mem[idx];

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[idx] <= wdata;
        end
    end

endmodule

//--- rtl/execUnit.sv
`timescale 1ns/1ps

module execUnit (
    input  logic            CLK,
    input  logic            rstN,
    ctrlIf.exec             ctrl,
    input  rvIsaPkg::word_t pc,
    input  rvIsaPkg::word_t rs1Data,
    input  rvIsaPkg::word_t rs2Data,
    output rvIsaPkg::word_t nextPc,
    output rvIsaPkg::word_t regData,
    output rvIsaPkg::word_t memAddr,
    output rvIsaPkg::word_t memData
);
    import rvIsaPkg::*;

    word_t opB;
    word_t aluResult;
    word_t loadData;
    word_t branchTarget;
    logic  zero;

    assign opB = ctrl.aluSrc ? ctrl.imm : rs2Data;

    always_comb begin
        case (ctrl.aluCtrl)
            ALU_SUB: aluResult = rs1Data - opB;
            ALU_AND: aluResult = rs1Data & opB;
            ALU_OR:  aluResult = rs1Data | opB;
            ALU_SLT: aluResult = {31'b0, $signed(rs1Data) < $signed(opB)};
            default: aluResult = rs1Data + opB;  // ALU_ADD
        endcase
    end

    // beq compares through the subtractor
    assign zero         = (aluResult == '0);
    assign branchTarget = pc + ctrl.imm;
    assign nextPc       = (ctrl.branch && zero) ? branchTarget : pc + 32'd4;

    assign memAddr = aluResult;
    assign memData = rs2Data;

    dataMem dmem_i (
        .CLK   (CLK),
        .rstN  (rstN),
        .we    (ctrl.memWrite),
        .addr  (aluResult),
        .wdata (rs2Data),
        .rdata (loadData)
    );

    assign regData = ctrl.memToReg ? loadData : aluResult;

endmodule

//--- rtl/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  logic            rstN,
    input  rvIsaPkg::word_t instr,
    ctrlIf.dec              ctrl
);
    import rvIsaPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    regAddr_t   rd;
    word_t      immI;
    word_t      immS;
    word_t      immB;
    aluCtrl_t   rAluCtrl;
    logic       rSupported;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    // Sign-extended immediates
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // R-type ALU control
    always_comb begin
        rSupported = 1'b1;
        case (funct3)
            F3_ADD:  rAluCtrl = funct7[FUNCT7_SUB_BIT] ? ALU_SUB : ALU_ADD;
            F3_AND:  rAluCtrl = ALU_AND;
            F3_OR:   rAluCtrl = ALU_OR;
            F3_SLT:  rAluCtrl = ALU_SLT;
            default: begin
                rAluCtrl   = ALU_ADD;
                rSupported = 1'b0;  // xor, shifts and the like
            end
        endcase
    end

    always_comb begin
        ctrl.regWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.aluCtrl  = ALU_ADD;
        ctrl.imm      = '0;
        if (rstN) begin
            case (opcode)
                OPC_RTYPE: begin
                    ctrl.regWrite = rSupported;
                    ctrl.aluCtrl  = rAluCtrl;
                end
                OPC_ADDI: begin
                    ctrl.regWrite = (funct3 == F3_ADD);
                    ctrl.aluSrc   = 1'b1;
                    ctrl.imm      = immI;
                end
                OPC_LOAD: begin
                    ctrl.regWrite = (funct3 == F3_LW);  // Word loads only
                    ctrl.aluSrc   = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.imm      = immI;
                end
                OPC_STORE: begin
                    ctrl.aluSrc   = 1'b1;
                    ctrl.memWrite = (funct3 == F3_SW);
                    ctrl.imm      = immS;
                end
                OPC_BRANCH: begin
                    ctrl.branch  = (funct3 == F3_BEQ);  // bne etc. fall through
                    ctrl.aluCtrl = ALU_SUB;
                    ctrl.imm     = immB;
                end
                default: ;  // Unknown opcode is a no-op
            endcase
            // x0 is never written
            if (rd == '0) begin
                ctrl.regWrite = 1'b0;
            end
        end
    end

endmodule

//--- rtl/instrMem.sv
`timescale 1ns/1ps

module instrMem (
    input  logic                CLK,
    input  logic                progWe,
    input  cpuCfgPkg::memAddr_t progAddr,
    input  rvIsaPkg::word_t     progData,
    input  rvIsaPkg::word_t     pc,
    output rvIsaPkg::word_t     instr
);
    import rvIsaPkg::*;
    import cpuCfgPkg::*;

    word_t mem [IMEM_DEPTH];

    // Fetch is asynchronous
    assign instr = mem[pc[MEM_ADDR_LO +: MEM_ADDR_W]];

    // Program load port
    always_ff @(posedge CLK) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end
    end

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic               CLK,
    input  logic               rstN,
    input  rvIsaPkg::regAddr_t rs1Addr,
    input  rvIsaPkg::regAddr_t rs2Addr,
    input  logic               regWrite,
    input  rvIsaPkg::regAddr_t regAddr,
    input  rvIsaPkg::word_t    regData,
    output rvIsaPkg::word_t    rs1Data,
    output rvIsaPkg::word_t    rs2Data
);
    import rvIsaPkg::*;

    word_t regs [NUM_REGS];

    // Reads see the value before this cycle's write
    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite) begin
            regs[regAddr] <= regData;  // Decoder already filtered x0
        end
    end

endmodule

//--- rtl/rvIsaPkg.sv
package rvIsaPkg;

    typedef logic [31:0] word_t;     // Data and instruction word
    typedef logic [4:0]  regAddr_t;  // Register index
    typedef logic [3:0]  aluCtrl_t;  // ALU operation select

    localparam int NUM_REGS = 32;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
    localparam logic [6:0] OPC_ADDI   = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // funct3 values
    localparam logic [2:0] F3_ADD = 3'b000;  // Also sub
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_SW  = 3'b010;

    // Bit of funct7 that turns add into sub
    localparam int FUNCT7_SUB_BIT = 5;

    // ALU control codes
    localparam aluCtrl_t ALU_ADD = 4'd0;
    localparam aluCtrl_t ALU_SUB = 4'd1;
    localparam aluCtrl_t ALU_AND = 4'd2;
    localparam aluCtrl_t ALU_OR  = 4'd3;
    localparam aluCtrl_t ALU_SLT = 4'd4;

endpackage

//--- rtl/singleCpu.sv
`timescale 1ns/1ps

module singleCpu (
    input  logic                CLK,
    input  logic                rstN,
    input  logic                progWe,
    input  cpuCfgPkg::memAddr_t progAddr,
    input  rvIsaPkg::word_t     progData,
    output rvIsaPkg::word_t     pc,
    output rvIsaPkg::word_t     instr,
    output logic                wbValid,
    output rvIsaPkg::regAddr_t  wbAddr,
    output rvIsaPkg::word_t     wbData,
    output logic                dmemWe,
    output rvIsaPkg::word_t     dmemAddr,
    output rvIsaPkg::word_t     dmemData
);
    import rvIsaPkg::*;
    import cpuCfgPkg::*;

    regAddr_t rs1Addr;
    regAddr_t rs2Addr;
    regAddr_t rdAddr;
    word_t    rs1Data;
    word_t    rs2Data;
    word_t    regData;
    word_t    nextPc;

    ctrlIf ctrl ();

    // One instruction per edge
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc <= RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    instrMem imem_i (
        .CLK      (CLK),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .instr    (instr)
    );

    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];
    assign rdAddr  = instr[11:7];

    instrDecoder dec_i (
        .rstN  (rstN),
        .instr (instr),
        .ctrl  (ctrl.dec)
    );

    regFile rf_i (
        .CLK      (CLK),
        .rstN     (rstN),
        .rs1Addr  (rs1Addr),
        .rs2Addr  (rs2Addr),
        .regWrite (ctrl.regWrite),
        .regAddr  (rdAddr),
        .regData  (regData),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data)
    );

    execUnit exec_i (
        .CLK     (CLK),
        .rstN    (rstN),
        .ctrl    (ctrl.exec),
        .pc      (pc),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .nextPc  (nextPc),
        .regData (regData),
        .memAddr (dmemAddr),
        .memData (dmemData)
    );

    // Trace of what commits at the next edge
    assign wbValid = ctrl.regWrite;
    assign wbAddr  = rdAddr;
    assign wbData  = regData;
    assign dmemWe  = ctrl.memWrite;

endmodule

//--- test/singleCpuTb.sv
`timescale 1ns/1ps

module singleCpuTb;
    import rvIsaPkg::*;
    import cpuCfgPkg::*;

    localparam int NUM_TESTS   = 6;
    localparam int TOTAL_STEPS = 2 + 8 + 5 + 15 + 4 + 40;
    // Each test loads the whole instruction memory during reset
    localparam int CYCLE_LIMIT = 2 * (NUM_TESTS * (IMEM_DEPTH + 2) + TOTAL_STEPS);

    logic     CLK = 1'b0;
    logic     rstN = 1'b1;
    logic     progWe = 1'b0;
    memAddr_t progAddr = '0;
    word_t    progData = '0;
    word_t    pc;
    word_t    instr;
    word_t    wbData;
    word_t    dmemAddr;
    word_t    dmemData;
    logic     wbValid;
    logic     dmemWe;
    regAddr_t wbAddr;

    word_t prog [$];
    word_t imemModel [IMEM_DEPTH];
    word_t regModel [NUM_REGS];
    word_t dmemModel [DMEM_DEPTH];
    word_t pcModel;
    int    errors = 0;
    int    cycles = 0;
    int    seed = 29;

    singleCpu dut_i (.*);

    always #4 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic word_t rType(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_RTYPE};
    endfunction

    function automatic word_t iType(int imm, int rs1, int rd, logic [6:0] opc);
        return {12'(imm), 5'(rs1), 3'b000, 5'(rd), opc} | (opc == OPC_LOAD ? 32'h2000 : 32'h0);
    endfunction

    function automatic word_t sType(int imm, int rs2, int rs1);
        logic [11:0] im;
        im = 12'(imm);
        return {im[11:5], 5'(rs2), 5'(rs1), F3_SW, im[4:0], OPC_STORE};
    endfunction

    function automatic word_t bType(int imm, int rs2, int rs1);
        logic [12:0] im;
        im = 13'(imm);
        return {im[12], im[10:5], 5'(rs2), 5'(rs1), F3_BEQ, im[4:1], im[11], OPC_BRANCH};
    endfunction

    task automatic checkVal(string name, word_t expVal, word_t gotVal);
        assert (expVal === gotVal) else begin
            $display("FAILED %s expected %h got %h", name, expVal, gotVal);
            errors++;
        end
    endtask

    // Loads prog during reset, remaining words get an address-tagged no-op
    task automatic loadAndReset();
        rstN = 1'b0;
        for (int w = 0; w < IMEM_DEPTH; w++) begin
            @(posedge CLK);
            #1;
            imemModel[w] = (w < prog.size()) ? prog[w] : iType(w, 0, 0, OPC_ADDI);
            progWe   = 1'b1;
            progAddr = memAddr_t'(w);
            progData = imemModel[w];
        end
        @(posedge CLK);
        #1;
        progWe = 1'b0;
        checkVal("pc", RESET_PC, pc);
        checkVal("wbValid", 0, wbValid);
        checkVal("dmemWe", 0, dmemWe);
        checkVal("instr", imemModel[0], instr);
        foreach (regModel[r]) regModel[r] = '0;
        foreach (dmemModel[m]) dmemModel[m] = '0;
        pcModel = RESET_PC;
        rstN = 1'b1;
    endtask

    // One instruction: compare at mid-cycle, update model at the edge
    task automatic stepCheck();
        word_t i;
        word_t a;
        word_t b;
        word_t res;
        word_t addr;
        word_t nxt;
        logic  expWb;
        logic  expSt;
        int    rd;
        i = imemModel[pcModel[7:2]];
        rd = i[11:7];
        a = regModel[i[19:15]];
        b = regModel[i[24:20]];
        expWb = 1'b0;
        expSt = 1'b0;
        res = '0;
        addr = '0;
        nxt = pcModel + 4;
        case (i[6:0])
            OPC_RTYPE: begin
                expWb = 1'b1;
                case (i[14:12])
                    3'b000: res = i[30] ? a - b : a + b;
                    3'b111: res = a & b;
                    3'b110: res = a | b;
                    3'b010: res = ($signed(a) < $signed(b)) ? 1 : 0;
                    default: expWb = 1'b0;
                endcase
            end
            OPC_ADDI: begin
                expWb = (i[14:12] == 3'b000);
                res = a + {{20{i[31]}}, i[31:20]};
            end
            OPC_LOAD: begin
                expWb = 1'b1;
                addr = a + {{20{i[31]}}, i[31:20]};
                res = dmemModel[addr[7:2]];
            end
            OPC_STORE: begin
                expSt = 1'b1;
                addr = a + {{20{i[31]}}, i[31:25], i[11:7]};
            end
            OPC_BRANCH: begin
                if (a == b) nxt = pcModel + {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
            end
            default: ;
        endcase
        expWb = expWb && (rd != 0);
        @(negedge CLK);
        checkVal("pc", pcModel, pc);
        checkVal("instr", i, instr);
        checkVal("wbValid", expWb, wbValid);
        checkVal("dmemWe", expSt, dmemWe);
        if (expWb) begin
            checkVal("wbAddr", rd, wbAddr);
            checkVal("wbData", res, wbData);
        end
        if (expSt) begin
            checkVal("dmemAddr", addr, dmemAddr);
            checkVal("dmemData", b, dmemData);
        end
        @(posedge CLK);
        if (expWb) regModel[rd] = res;
        if (expSt) dmemModel[addr[7:2]] = b;
        pcModel = nxt;
        #1;
    endtask

    task automatic runTest(string name, int steps);
        int errBefore;
        errBefore = errors;
        loadAndReset();
        repeat (steps) stepCheck();
        $display("%-8s %s", name, (errors == errBefore) ? "ok" : "mismatch");
    endtask

    task automatic resetTest();
        prog = {iType(5, 0, 1, OPC_ADDI), iType(1, 1, 2, OPC_ADDI)};
        runTest("reset", 2);
    endtask

    task automatic aluTest();
        prog = {iType(-7, 0, 1, OPC_ADDI), iType(12, 0, 2, OPC_ADDI),
                rType(0, 2, 1, 3'b000, 3), rType(7'h20, 2, 1, 3'b000, 4),
                rType(0, 2, 1, 3'b111, 5), rType(0, 2, 1, 3'b110, 6),
                rType(0, 2, 1, 3'b010, 7), rType(0, 1, 2, 3'b010, 8)};
        runTest("alu", 8);
    endtask

    task automatic memTest();
        prog = {iType(64, 0, 1, OPC_ADDI), iType(-3, 0, 2, OPC_ADDI),
                sType(8, 2, 1), iType(8, 1, 3, OPC_LOAD), rType(0, 3, 3, 3'b000, 4)};
        runTest("memory", 5);
    endtask

    task automatic branchTest();
        prog = {iType(3, 0, 1, OPC_ADDI), iType(3, 0, 2, OPC_ADDI), bType(12, 2, 1),
                iType(1, 0, 3, OPC_ADDI), iType(1, 0, 4, OPC_ADDI), bType(8, 0, 1),
                iType(1, 0, 5, OPC_ADDI), iType(-1, 1, 1, OPC_ADDI), bType(8, 0, 1),
                bType(-8, 0, 0), iType(9, 0, 6, OPC_ADDI)};
        runTest("branch", 15);
    endtask

    task automatic zeroRegTest();
        prog = {iType(5, 0, 0, OPC_ADDI), iType(7, 0, 1, OPC_ADDI),
                rType(0, 1, 1, 3'b000, 0), rType(0, 1, 0, 3'b000, 2)};
        runTest("x0", 4);
    endtask

    task automatic randomTest();
        logic [2:0] f3s [5];
        int kind;
        f3s = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b010};
        prog = {};
        for (int n = 0; n < 40; n++) begin
            kind = ($random(seed) & 32'h7fff_ffff) % 6;
            if (kind == 5) begin
                prog.push_back(iType($random(seed), $random(seed), $random(seed), OPC_ADDI));
            end else begin
                prog.push_back(rType(kind == 1 ? 7'h20 : 7'h00, $random(seed), $random(seed),
                                     f3s[kind], $random(seed)));
            end
        end
        runTest("random", 40);
    endtask

    initial begin
        #1;
        resetTest();
        aluTest();
        memTest();
        branchTest();
        zeroRegTest();
        randomTest();
        $display("Tests run %0d, errors %0d, property failures %0d, cycles %0d",
                 NUM_TESTS, errors, dut_i.props_i.errCount, cycles);
        if (errors == 0 && dut_i.props_i.errCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- test/singleCpu_props.sv
`timescale 1ns/1ps

module singleCpu_props (
    input logic            CLK,
    input logic            rstN,
    input rvIsaPkg::word_t pc,
    input rvIsaPkg::word_t instr,
    input logic            wbValid,
    input logic            dmemWe
);
    import rvIsaPkg::*;
    import cpuCfgPkg::*;

    int errCount = 0;  // Failed property attempts

    // Core held quiet in reset
    assert property (@(posedge CLK) !rstN |-> (pc == RESET_PC && !wbValid && !dmemWe))
        else begin
            $error("Core active during reset");
            errCount++;
        end

    assert property (@(posedge CLK) pc[1:0] == 2'b00)
        else begin
            $error("pc not word aligned");
            errCount++;
        end

    assert property (@(posedge CLK) !(wbValid && dmemWe))
        else begin
            $error("Write-back and store in one cycle");
            errCount++;
        end

    // Non-branch instructions fall through
    assert property (@(posedge CLK) disable iff (!rstN)
        (instr[6:0] != OPC_BRANCH) |=> pc == $past(pc) + 32'd4)
        else begin
            $error("pc did not advance by 4");
            errCount++;
        end

endmodule

bind singleCpu singleCpu_props props_i (.*);
